//--- boothConv.f
logic/convDataPkg.sv
logic/convFlowPkg.sv
logic/sampleBank.sv
logic/boothMultiplier.sv
logic/convSequencer.sv
logic/convTop.sv
verification/convTb_asserts.sv
verification/convTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the convolution engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f boothConv.f --top-module convTb -o simConv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simConv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verification/convTb.sv
// Testbench for convTop with stimulus table, reference model and credit consumer
`timescale 1ns/100ps

module convTb import convDataPkg::*; import convFlowPkg::*;;

    localparam int Outputs = 2 * SampleCount - 1;
    localparam int Tests = 4;

    logic clk;
    logic rstN;
    logic loadEn;
    logic [SampleCount*SampleWidth-1:0] samplesA;
    logic [SampleCount*SampleWidth-1:0] samplesB;
    logic start;
    logic creditReturn;
    logic busy;
    logic done;
    logic resultValid;
    indexT resultIndex;
    resultT resultData;

    // Stimulus table: sequences, expected done pulses, credits withheld
    logic [63:0] tableA [Tests] = '{64'h0000_0000_0000_0001, 64'h0101_0101_0101_0101,
                                    64'h8080_8080_8080_8080, 64'h7F80_05FE_3C9C_01FF};
    logic [63:0] tableB [Tests] = '{64'h0807_06FA_FB04_FD02, 64'h0101_0101_0101_0101,
                                    64'h8080_8080_8080_8080, 64'hC312_807F_E033_F108};
    int tableDone [Tests] = '{1, 1, 1, 1};
    bit tableHold [Tests] = '{0, 0, 0, 1};

    logic [63:0] curA = '0; // Contents the bank should hold
    logic [63:0] curB = '0;
    int gotData [Outputs];
    int gotCount;
    int doneCount;
    int cycle;
    int creditDue [$];
    bit withhold;
    int checks;
    int errors;
    logic [31:0] lcgState = 32'h0753_1195;

    convTop u_convTop (
        .clk(clk), .rstN(rstN), .loadEn(loadEn), .samplesA(samplesA),
        .samplesB(samplesB), .start(start), .creditReturn(creditReturn),
        .busy(busy), .done(done), .resultValid(resultValid),
        .resultIndex(resultIndex), .resultData(resultData)
    );

    bind convSequencer convTb_asserts u_asserts (
        .clk(clk), .rstN(rstN), .resultValid(resultValid), .creditReturn(creditReturn),
        .mulStart(mulStart), .productValid(productValid), .done(done)
    );

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Reference sum of a[i]*b[k-i] over valid i
    function automatic int expectedSum(logic [63:0] pa, logic [63:0] pb, int k);
        int sum;
        sum = 0;
        for (int i = 0; i < SampleCount; i++) begin
            if (k - i >= 0 && k - i < SampleCount) begin
                sum += int'($signed(pa[i*8 +: 8])) * int'($signed(pb[(k-i)*8 +: 8]));
            end
        end
        return sum;
    endfunction

    task automatic checkValue(string name, int expected, int actual);
        checks++;
        assert (expected == actual) else begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                $time, name, expected, actual);
            errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Consumer takes results and schedules credit returns
    always @(negedge clk) begin
        if (rstN && resultValid) begin
            checkValue("resultIndex", gotCount, int'(resultIndex));
            if (gotCount < Outputs) gotData[gotCount] = int'(resultData);
            gotCount++;
            creditDue.push_back(cycle + int'(lcgNext() % 8));
        end
        if (rstN && done) doneCount++;
    end

    always @(posedge clk) begin
        creditReturn <= 1'b0;
        if (!withhold && creditDue.size() > 0 && creditDue[0] <= cycle) begin
            creditReturn <= 1'b1;
            void'(creditDue.pop_front());
        end
    end

    task automatic loadSamples(logic [63:0] pa, logic [63:0] pb);
        @(posedge clk);
        loadEn <= 1'b1;
        samplesA <= pa;
        samplesB <= pb;
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    task automatic waitCreditsHome();
        int t;
        for (t = 0; t < 200 && creditDue.size() > 0; t++) @(negedge clk);
        if (creditDue.size() > 0) begin
            $display("Timeout: consumer credits were not returned");
            errors++;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic runConv(string name, bit hold, bit loadMidRun, int expDone);
        int errBefore;
        int t;
        errBefore = errors;
        waitCreditsHome();
        gotCount = 0;
        doneCount = 0;
        withhold = hold;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (loadMidRun) begin
            loadSamples(~curA, curB ^ 64'h5A5A_5A5A_5A5A_5A5A); // Must be ignored
        end
        if (hold) begin
            for (t = 0; t < 2000 && gotCount < CreditMax; t++) @(negedge clk);
            if (gotCount < CreditMax) begin
                $display("Timeout: run %s gave fewer results than credits", name);
                errors++;
            end
            repeat (300) @(negedge clk);
            checks++;
            assert (gotCount <= CreditMax) else begin
                $display("More results than credits while credits were withheld");
                errors++;
            end
            withhold = 1'b0;
        end
        for (t = 0; t < 20000 && (gotCount < Outputs || busy); t++) @(negedge clk);
        if (gotCount < Outputs || busy) begin
            $display("Timeout: run %s did not finish", name);
            errors++;
        end
        repeat (3) @(negedge clk);
        checkValue("result count", Outputs, gotCount);
        checkValue("done", expDone, doneCount);
        for (int k = 0; k < Outputs; k++) begin
            checkValue($sformatf("resultData[%0d]", k), expectedSum(curA, curB, k), gotData[k]);
        end
        $display("Test %s: %s", name, (errors == errBefore) ? "ok" : "failed");
    endtask

    initial begin
        rstN = 1'b0;
        loadEn = 1'b0;
        samplesA = '0;
        samplesB = '0;
        start = 1'b0;
        creditReturn = 1'b0;
        withhold = 1'b0;
        cycle = 0;
        checks = 0;
        errors = 0;
        gotCount = 0;
        doneCount = 0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("busy", 0, int'(busy));
        checkValue("done", 0, int'(done));
        checkValue("resultValid", 0, int'(resultValid));
        runConv("reset zeros", 1'b0, 1'b0, 1);

        for (int n = 0; n < Tests; n++) begin
            loadSamples(tableA[n], tableB[n]);
            curA = tableA[n];
            curB = tableB[n];
            runConv($sformatf("table %0d", n), tableHold[n], n == Tests - 1, tableDone[n]);
        end
        runConv("load while busy", 1'b0, 1'b0, 1); // Last entry data still in the bank

        for (int r = 0; r < 3; r++) begin
            curA = {lcgNext(), lcgNext()};
            curB = {lcgNext(), lcgNext()};
            loadSamples(curA, curB);
            runConv($sformatf("random %0d", r), 1'b0, 1'b0, 1);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Overall limit on simulation time
    initial begin
        #2ms;
        $display("Timeout: simulation limit reached");
        $display("Checks failed");
        $finish;
    end

endmodule

//--- verification/convTb_asserts.sv
// Bound assertions on credit use, multiplier issue and done timing
`timescale 1ns/100ps

module convTb_asserts import convDataPkg::*; import convFlowPkg::*; (
    input logic clk,
    input logic rstN,
    input logic resultValid,
    input logic creditReturn,
    input logic mulStart,
    input logic productValid,
    input logic done
);

    localparam int LastIndex = 2 * SampleCount - 2;

    logic pending; // Product requested but not yet returned
    int creditModel;   // Credits granted by the consumer and not yet spent
    int issued;        // Results so far in the current run

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pending <= 1'b0;
        end else if (mulStart) begin
            pending <= 1'b1;
        end else if (productValid) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            creditModel <= CreditMax;
            issued <= 0;
        end else begin
            creditModel <= creditModel + int'(creditReturn) - int'(resultValid);
            if (resultValid) begin
                issued <= (issued == LastIndex) ? 0 : issued + 1;
            end
        end
    end

    noResultWithoutCredit: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> creditModel > 0) else $error("result issued with zero credits");

    noStartWhilePending: assert property (@(posedge clk) disable iff (!rstN)
        mulStart |-> !pending) else $error("multiply started while a product is pending");

    doneOnLastResult: assert property (@(posedge clk) disable iff (!rstN)
        done == (resultValid && issued == LastIndex))
        else $error("done does not match the last result");

endmodule

//--- logic/convTop.sv
// Top level connecting sample bank, Booth multiplier and convolution sequencer
`timescale 1ns/100ps

module convTop import convDataPkg::*; import convFlowPkg::*; #(
    parameter int SampleWidth = convDataPkg::SampleWidth,
    parameter int SampleCount = convDataPkg::SampleCount,
    parameter int CreditMax = convFlowPkg::CreditMax
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             loadEn,
    input  logic [SampleCount*SampleWidth-1:0] samplesA,
    input  logic [SampleCount*SampleWidth-1:0] samplesB,
    input  logic                             start,
    input  logic                             creditReturn,
    output logic                             busy,
    output logic                             done,
    output logic                             resultValid,
    output indexT                            resultIndex,
    output resultT                           resultData
);

    indexT selA;
    indexT selB;
    sampleT operandA;
    sampleT operandB;
    logic mulStart;
    logic productValid;
    productT product;

    sampleBank #(
        .SampleWidth(SampleWidth),
        .SampleCount(SampleCount)
    ) u_sampleBank (
        .clk(clk),
        .rstN(rstN),
        .loadEn(loadEn),
        .busy(busy),
        .samplesA(samplesA),
        .samplesB(samplesB),
        .selA(selA),
        .selB(selB),
        .operandA(operandA),
        .operandB(operandB)
    );

    boothMultiplier #(
        .SampleWidth(SampleWidth)
    ) u_boothMultiplier (
        .clk(clk),
        .rstN(rstN),
        .mulStart(mulStart),
        .multiplicand(operandA),
        .multiplier(operandB),
        .productValid(productValid),
        .product(product)
    );

    convSequencer #(
        .SampleCount(SampleCount),
        .CreditMax(CreditMax)
    ) u_convSequencer (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .creditReturn(creditReturn),
        .productValid(productValid),
        .product(product),
        .busy(busy),
        .done(done),
        .mulStart(mulStart),
        .selA(selA),
        .selB(selB),
        .resultValid(resultValid),
        .resultIndex(resultIndex),
        .resultData(resultData)
    );

endmodule

//--- logic/convSequencer.sv
// Output and term index walker with accumulation and credit-gated result issue
`timescale 1ns/100ps

module convSequencer import convDataPkg::*; import convFlowPkg::*; #(
    parameter int SampleCount = convDataPkg::SampleCount,
    parameter int CreditMax = convFlowPkg::CreditMax
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    start,
    input  logic    creditReturn,
    input  logic    productValid,
    input  productT product,
    output logic    busy,
    output logic    done,
    output logic    mulStart,
    output indexT   selA,
    output indexT   selB,
    output logic    resultValid,
    output indexT   resultIndex,
    output resultT  resultData
);

    localparam int LastIndex = 2 * SampleCount - 2;

    typedef enum logic [1:0] {
        Idle,
        MulIssue,
        MulWait,
        Emit
    } seqStateT;

    seqStateT state;
    indexT outIdx;    // k
    indexT termIdx;   // j
    indexT nextIdx;
    resultT accSum;
    resultT productExt;
    creditT credits;
    logic lastTerm;
    logic lastOutput;

    // Lowest j with k-j still inside the sequence
    function automatic indexT termLow(indexT k);
        if (int'(k) >= SampleCount) begin
            return indexT'(int'(k) - SampleCount + 1);
        end
        return '0;
    endfunction

    function automatic indexT termHigh(indexT k);
        if (int'(k) < SampleCount) begin
            return k;
        end
        return indexT'(SampleCount - 1);
    endfunction

    assign nextIdx = outIdx + 1'b1;
    assign lastTerm = (termIdx == termHigh(outIdx));
    assign lastOutput = (int'(outIdx) == LastIndex);
    assign productExt = {{(ResultWidth - ProductWidth){product[ProductWidth-1]}}, product};

    assign busy = (state != Idle);
    assign mulStart = (state == MulIssue); // Multiplier is idle here
    assign selA = termIdx;                 // a[j]
    assign selB = outIdx - termIdx;        // b[k-j]

    // Finished sum held until a credit is available
    assign resultValid = (state == Emit) && (credits != '0);
    assign resultIndex = outIdx;
    assign resultData = accSum;
    assign done = resultValid && lastOutput;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Idle;
            outIdx <= '0;
            termIdx <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (start) begin
                        state <= MulIssue;
                        outIdx <= '0;
                        termIdx <= '0;
                        accSum <= '0;
                    end
                end
                MulIssue: state <= MulWait;
                MulWait: begin
                    if (productValid) begin
                        accSum <= accSum + productExt;
                        if (lastTerm) begin
                            state <= Emit;
                        end else begin
                            termIdx <= termIdx + 1'b1;
                            state <= MulIssue;
                        end
                    end
                end
                Emit: begin
                    if (resultValid) begin
                        accSum <= '0;
                        if (lastOutput) begin
                            state <= Idle;
                        end else begin
                            outIdx <= nextIdx;
                            termIdx <= termLow(nextIdx);
                            state <= MulIssue;
                        end
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Return and spend may land on the same edge
    always_ff @(posedge clk) begin
        if (!rstN) begin
            credits <= creditT'(CreditMax);
        end else begin
            credits <= credits + creditT'(creditReturn) - creditT'(resultValid);
        end
    end

endmodule

//--- logic/boothMultiplier.sv
// Sequential radix-2 Booth multiplier, datapath and control together
`timescale 1ns/100ps

module boothMultiplier import convDataPkg::*; #(
    parameter int SampleWidth = convDataPkg::SampleWidth
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    mulStart,
    input  sampleT  multiplicand,
    input  sampleT  multiplier,
    output logic    productValid,
    output productT product
);

    localparam int CountWidth = $clog2(SampleWidth + 1);

    typedef enum logic {
        Idle,
        Iterate
    } mulStateT;

    mulStateT state;
    logic [CountWidth-1:0] count;   // Iterations left
    logic signed [SampleWidth:0] accReg;   // Extra top bit so subtracting -2^(n-1) cannot overflow
    logic signed [SampleWidth:0] mcandReg;
    logic [SampleWidth-1:0] mplierReg;
    logic qMinus1;
    logic signed [SampleWidth:0] accNext;
    logic load;

    assign load = (state == Idle) && mulStart;

    // Booth recoding of the two low bits
    always_comb begin
        unique case ({mplierReg[0], qMinus1})
            2'b01:   accNext = accReg + mcandReg;
            2'b10:   accNext = accReg - mcandReg;
            default: accNext = accReg;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Idle;
            count <= '0;
            productValid <= 1'b0;
        end else begin
            productValid <= 1'b0;
            case (state)
                Idle: begin
                    if (mulStart) begin
                        state <= Iterate;
                        count <= CountWidth'(SampleWidth);
                    end
                end
                Iterate: begin
                    count <= count - 1'b1;
                    if (count == CountWidth'(1)) begin // Last add and shift
                        state <= Idle;
                        productValid <= 1'b1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            accReg <= '0;
            mcandReg <= {multiplicand[SampleWidth-1], multiplicand};
            mplierReg <= multiplier;
            qMinus1 <= 1'b0;
        end else if (state == Iterate) begin
            // Arithmetic shift right across accumulator and multiplier
            accReg <= {accNext[SampleWidth], accNext[SampleWidth:1]};
            mplierReg <= {accNext[0], mplierReg[SampleWidth-1:1]};
            qMinus1 <= mplierReg[0];
        end
    end

    assign product = {accReg[SampleWidth-1:0], mplierReg}; // Fits in 2n bits for every pair

endmodule

//--- logic/sampleBank.sv
// Register bank for both sample sequences with indexed operand select
`timescale 1ns/100ps

module sampleBank import convDataPkg::*; #(
    parameter int SampleWidth = convDataPkg::SampleWidth,
    parameter int SampleCount = convDataPkg::SampleCount
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             loadEn,
    input  logic                             busy,
    input  logic [SampleCount*SampleWidth-1:0] samplesA,
    input  logic [SampleCount*SampleWidth-1:0] samplesB,
    input  indexT                            selA,
    input  indexT                            selB,
    output sampleT                           operandA,
    output sampleT                           operandB
);

    localparam int SelWidth = $clog2(SampleCount);

    sampleT bankA [SampleCount];
    sampleT bankB [SampleCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < SampleCount; i++) begin
                bankA[i] <= '0;
                bankB[i] <= '0;
            end
        end else if (loadEn && !busy) begin // Loads during a run are dropped
            for (int i = 0; i < SampleCount; i++) begin
                bankA[i] <= samplesA[i*SampleWidth +: SampleWidth];
                bankB[i] <= samplesB[i*SampleWidth +: SampleWidth];
            end
        end
    end

    // Sequencer keeps both selects inside the bank
    assign operandA = bankA[selA[SelWidth-1:0]];
    assign operandB = bankB[selB[SelWidth-1:0]];

endmodule

//--- logic/convFlowPkg.sv
// Credit limit and credit counter type for result stream flow control
package convFlowPkg;

    // Credits granted by the consumer out of reset
    localparam int CreditMax = 4;

    typedef logic [$clog2(CreditMax + 1)-1:0] creditT;

endpackage

//--- logic/convDataPkg.sv
// Sample, product and result formats plus index width for the convolution engine
package convDataPkg;

    localparam int SampleWidth = 8;
    localparam int SampleCount = 8;
    localparam int ProductWidth = 2 * SampleWidth;

    // Growth bits for summing up to SampleCount products
    localparam int ResultWidth = ProductWidth + $clog2(SampleCount);

    localparam int IndexWidth = $clog2(2 * SampleCount - 1);

    typedef logic signed [SampleWidth-1:0] sampleT;
    typedef logic signed [ProductWidth-1:0] productT;
    typedef logic signed [ResultWidth-1:0] resultT;
    typedef logic [IndexWidth-1:0] indexT;

endpackage
